//--- rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sType_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		logic [6:0] opcode;
	} bType_t;

	typedef struct packed {
		logic [19:0] imm31to12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uType_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jType_t;

	// one instruction word, six ways of reading it
	typedef union packed {
		rType_t rType;
		iType_t iType;
		sType_t sType;
		bType_t bType;
		uType_t uType;
		jType_t jType;
	} rvInst_t;

	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;

	// loads
	localparam logic [2:0] f3Lb  = 3'b000;
	localparam logic [2:0] f3Lh  = 3'b001;
	localparam logic [2:0] f3Lw  = 3'b010;
	localparam logic [2:0] f3Lbu = 3'b100;
	localparam logic [2:0] f3Lhu = 3'b101;
	// stores
	localparam logic [2:0] f3Sb = 3'b000;
	localparam logic [2:0] f3Sh = 3'b001;
	localparam logic [2:0] f3Sw = 3'b010;
	// jumps and branches
	localparam logic [2:0] f3Jalr = 3'b000;
	localparam logic [2:0] f3Beq  = 3'b000;
	// alu, shared by opImm and opReg
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt  = 7'b0100000; // sub, sra

	localparam logic [31:0] instEbreak = 32'h00100073;

endpackage

`default_nettype wire

//--- cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

	// alu operation
	localparam logic [3:0] aluAdd   = 4'd0;
	localparam logic [3:0] aluSub   = 4'd1;
	localparam logic [3:0] aluSll   = 4'd2;
	localparam logic [3:0] aluSlt   = 4'd3;
	localparam logic [3:0] aluSltu  = 4'd4;
	localparam logic [3:0] aluXor   = 4'd5;
	localparam logic [3:0] aluSrl   = 4'd6;
	localparam logic [3:0] aluSra   = 4'd7;
	localparam logic [3:0] aluOr    = 4'd8;
	localparam logic [3:0] aluAnd   = 4'd9;
	localparam logic [3:0] aluPassB = 4'd10; // lui

	// register writeback source
	localparam logic [1:0] wbAlu     = 2'd0;
	localparam logic [1:0] wbMem     = 2'd1;
	localparam logic [1:0] wbPcPlus4 = 2'd2; // jal, jalr link
	localparam logic [1:0] wbPcImm   = 2'd3; // auipc

	// next pc source
	localparam logic [1:0] pcSelPlus4  = 2'd0;
	localparam logic [1:0] pcSelBranch = 2'd1; // beq when taken, jal always
	localparam logic [1:0] pcSelJalr   = 2'd2;

	// access size in bytes
	localparam logic [2:0] sizeByte = 3'd1;
	localparam logic [2:0] sizeHalf = 3'd2;
	localparam logic [2:0] sizeWord = 3'd4;

endpackage

`default_nettype wire

//--- pcCounter.sv
`timescale 1ns/1ns
`default_nettype none

module pcCounter import cpuCtrlPkg::*; #(
	parameter logic [31:0] resetVector = 32'h80000000
) (
	input  wire         clk,
	input  wire         rstN,
	input  wire  [1:0]  pcSel,
	input  wire         branch,
	input  wire         zero,
	input  wire         halt,
	input  wire  [31:0] jalrTarget,
	input  wire  [31:0] immediate,
	output logic [31:0] pc,
	output logic [31:0] pcPlus4
);

	logic [31:0] pcImm;
	logic [31:0] pcNext;

	assign pcPlus4 = pc + 32'd4;
	assign pcImm = pc + immediate;

	always_comb begin
		case (pcSel)
			pcSelBranch: pcNext = (!branch || zero) ? pcImm : pcPlus4; // jal has branch low
			pcSelJalr:   pcNext = {jalrTarget[31:1], 1'b0};
			default:     pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetVector;
		end else if (!halt) begin
			pc <= pcNext; // halt freezes the core here
		end
	end

	// branch and jal offsets come from the decoder with bit 0 clear
	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0)
		else $error("pc misaligned: %h", pc);

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  wire         clk,
	input  wire         rstN,
	input  wire         regWrite,
	input  wire  [4:0]  rd,
	input  wire  [4:0]  rs1Addr,
	input  wire  [4:0]  rs2Addr,
	input  wire  [31:0] writeData,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && rd != 5'd0) begin
			regs[rd] <= writeData; // x0 never written
		end
	end

	// combinational reads
	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	// x0 stays zero only if reset cleared it and no write ever reached it
	x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
		(rs1Addr != 5'd0 || rs1Data == '0) && (rs2Addr != 5'd0 || rs2Data == '0))
		else $error("x0 read back nonzero");

endmodule

`default_nettype wire

//--- instDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instDecoder import rvIsaPkg::*, cpuCtrlPkg::*; (
	input  wire  [31:0] inst,
	output logic [3:0]  aluOp,
	output logic        aluSrcImm,
	output logic        aluSrcPc,
	output logic [31:0] imm,
	output logic [4:0]  rd,
	output logic [4:0]  rs1Addr,
	output logic [4:0]  rs2Addr,
	output logic        regWrite,
	output logic        memWrite,
	output logic        memRead,
	output logic [2:0]  memSize,
	output logic        memSigned,
	output logic [1:0]  wbSel,
	output logic [1:0]  pcSel,
	output logic        branch,
	output logic        invalid,
	output logic        ebreak,
	output logic        halt
);

	rvInst_t     word;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;
	logic        legal;
	logic        regWriteRaw;
	logic        memWriteRaw;
	logic        memReadRaw;

	function automatic logic [3:0] aluOpOf(input logic [2:0] funct3, input logic alt);
		logic [3:0] op;
		case (funct3)
			f3AddSub: op = alt ? aluSub : aluAdd;
			f3Sll:    op = aluSll;
			f3Slt:    op = aluSlt;
			f3Sltu:   op = aluSltu;
			f3Xor:    op = aluXor;
			f3SrlSra: op = alt ? aluSra : aluSrl;
			f3Or:     op = aluOr;
			default:  op = aluAnd;
		endcase
		return op;
	endfunction

	// low two funct3 bits give the width for loads and stores
	function automatic logic [2:0] sizeOf(input logic [1:0] code);
		logic [2:0] size;
		case (code)
			2'b00:   size = sizeByte;
			2'b01:   size = sizeHalf;
			default: size = sizeWord;
		endcase
		return size;
	endfunction

	assign word = inst;
	assign f3 = word.rType.funct3;
	assign f7 = word.rType.funct7;
	assign rd = word.rType.rd;
	assign rs1Addr = word.rType.rs1;
	assign rs2Addr = word.rType.rs2;

	assign immI = {{20{word.iType.imm[11]}}, word.iType.imm};
	assign immS = {{20{word.sType.immHi[6]}}, word.sType.immHi, word.sType.immLo};
	assign immB = {{19{word.bType.imm12}}, word.bType.imm12, word.bType.imm11,
		word.bType.imm10to5, word.bType.imm4to1, 1'b0};
	assign immU = {word.uType.imm31to12, 12'b0};
	assign immJ = {{11{word.jType.imm20}}, word.jType.imm20, word.jType.imm19to12,
		word.jType.imm11, word.jType.imm10to1, 1'b0};

	always_comb begin
		legal = 1'b0;
		aluOp = aluAdd;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		imm = immI;
		regWriteRaw = 1'b0;
		memWriteRaw = 1'b0;
		memReadRaw = 1'b0;
		memSize = sizeWord;
		memSigned = 1'b0;
		wbSel = wbAlu;
		pcSel = pcSelPlus4;
		branch = 1'b0;
		case (word.rType.opcode)
			opLui: begin
				legal = 1'b1;
				aluOp = aluPassB;
				aluSrcImm = 1'b1;
				imm = immU;
				regWriteRaw = 1'b1;
			end
			opAuipc: begin
				legal = 1'b1;
				aluSrcPc = 1'b1; // alu sees pc + imm as well
				aluSrcImm = 1'b1;
				imm = immU;
				regWriteRaw = 1'b1;
				wbSel = wbPcImm;
			end
			opJal: begin
				legal = 1'b1;
				imm = immJ;
				regWriteRaw = 1'b1;
				wbSel = wbPcPlus4;
				pcSel = pcSelBranch;
			end
			opJalr: begin
				legal = (f3 == f3Jalr);
				aluSrcImm = 1'b1; // target = rs1 + imm
				regWriteRaw = 1'b1;
				wbSel = wbPcPlus4;
				pcSel = pcSelJalr;
			end
			opBranch: begin
				legal = (f3 == f3Beq);
				aluOp = aluSub; // zero flag means equal
				imm = immB;
				pcSel = pcSelBranch;
				branch = 1'b1;
			end
			opLoad: begin
				legal = (f3 == f3Lb) || (f3 == f3Lh) || (f3 == f3Lw) ||
					(f3 == f3Lbu) || (f3 == f3Lhu);
				aluSrcImm = 1'b1;
				regWriteRaw = 1'b1;
				memReadRaw = 1'b1;
				memSize = sizeOf(f3[1:0]);
				memSigned = !f3[2];
				wbSel = wbMem;
			end
			opStore: begin
				legal = (f3 == f3Sb) || (f3 == f3Sh) || (f3 == f3Sw);
				aluSrcImm = 1'b1;
				imm = immS;
				memWriteRaw = 1'b1;
				memSize = sizeOf(f3[1:0]);
			end
			opImm: begin
				legal = (f3 != f3Sll) && (f3 != f3SrlSra); // no immediate shifts
				aluOp = aluOpOf(f3, 1'b0);
				aluSrcImm = 1'b1;
				regWriteRaw = 1'b1;
			end
			opReg: begin
				legal = (f7 == f7Base) || (f7 == f7Alt && (f3 == f3AddSub || f3 == f3SrlSra));
				aluOp = aluOpOf(f3, f7 == f7Alt);
				regWriteRaw = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	assign ebreak = (inst == instEbreak);
	assign invalid = !legal && !ebreak;
	assign halt = invalid || ebreak;

	// a halted cycle leaves no trace in registers or memory
	assign regWrite = regWriteRaw && !halt;
	assign memWrite = memWriteRaw && !halt;
	assign memRead = memReadRaw && !halt;

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import cpuCtrlPkg::*; (
	input  wire  [3:0]  aluOp,
	input  wire         aluSrcImm,
	input  wire         aluSrcPc,
	input  wire  [31:0] rs1Data,
	input  wire  [31:0] rs2Data,
	input  wire  [31:0] pc,
	input  wire  [31:0] imm,
	output logic [31:0] result,
	output logic        zero
);

	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [4:0]  shamt;

	assign srcA = aluSrcPc ? pc : rs1Data; // pc only for auipc
	assign srcB = aluSrcImm ? imm : rs2Data;
	assign shamt = srcB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd:   result = srcA + srcB;
			aluSub:   result = srcA - srcB;
			aluSll:   result = srcA << shamt;
			aluSlt:   result = {31'b0, $signed(srcA) < $signed(srcB)};
			aluSltu:  result = {31'b0, srcA < srcB};
			aluXor:   result = srcA ^ srcB;
			aluSrl:   result = srcA >> shamt;
			aluSra:   result = $unsigned($signed(srcA) >>> shamt);
			aluOr:    result = srcA | srcB;
			aluAnd:   result = srcA & srcB;
			aluPassB: result = srcB;
			default:  result = '0;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

//--- memWriteback.sv
`timescale 1ns/1ns
`default_nettype none

module memWriteback import cpuCtrlPkg::*; (
	input  wire         clk,
	input  wire         rstN,
	input  wire         memWrite,
	input  wire         memRead,
	input  wire  [2:0]  memSize,
	input  wire         memSigned,
	input  wire  [1:0]  wbSel,
	input  wire  [31:0] aluResult,
	input  wire  [31:0] storeData,
	input  wire  [31:0] pc,
	input  wire  [31:0] pcPlus4,
	input  wire  [31:0] imm,
	input  wire  [31:0] memRdata,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata,
	output logic [7:0]  memWmask,
	output logic        memWen,
	output logic        memRen,
	output logic [31:0] writeData
);

	logic [7:0]  sizeMask;
	logic [31:0] loadData;

	// store data goes out unshifted, mask picks the low bytes
	assign memAddr = aluResult;
	assign memWdata = storeData;
	assign memWen = memWrite;
	assign memRen = memRead;

	always_comb begin
		case (memSize)
			sizeByte: sizeMask = 8'h01;
			sizeHalf: sizeMask = 8'h03;
			default:  sizeMask = 8'h0f;
		endcase
	end

	assign memWmask = memWrite ? sizeMask : 8'h00;

	always_comb begin
		case (memSize)
			sizeByte: loadData = {{24{memSigned & memRdata[7]}}, memRdata[7:0]};
			sizeHalf: loadData = {{16{memSigned & memRdata[15]}}, memRdata[15:0]};
			default:  loadData = memRdata;
		endcase
	end

	always_comb begin
		case (wbSel)
			wbMem:     writeData = loadData;
			wbPcPlus4: writeData = pcPlus4;
			wbPcImm:   writeData = pc + imm;
			default:   writeData = aluResult;
		endcase
	end

	// decoder never asks for a load and a store in the same cycle
	noReadWrite: assert property (@(posedge clk) disable iff (!rstN) !(memWen && memRen))
		else $error("memWen and memRen both high at %h", memAddr);

endmodule

`default_nettype wire

//--- cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTop #(
	parameter logic [31:0] resetVector = 32'h80000000
) (
	input  wire         clk,
	input  wire         rstN,
	input  wire  [31:0] inst,
	input  wire  [31:0] memRdata,
	output wire  [31:0] pc,
	output wire         invalid,
	output wire         ebreak,
	output wire  [31:0] memAddr,
	output wire  [31:0] memWdata,
	output wire  [7:0]  memWmask,
	output wire         memWen,
	output wire         memRen
);

	// decoder controls
	wire [3:0]  aluOp;
	wire        aluSrcImm;
	wire        aluSrcPc;
	wire [31:0] imm;
	wire [4:0]  rd;
	wire [4:0]  rs1Addr;
	wire [4:0]  rs2Addr;
	wire        regWrite;
	wire        memWrite;
	wire        memRead;
	wire [2:0]  memSize;
	wire        memSigned;
	wire [1:0]  wbSel;
	wire [1:0]  pcSel;
	wire        branch;
	wire        halt;

	// datapath
	wire [31:0] rs1Data;
	wire [31:0] rs2Data;
	wire [31:0] aluResult;
	wire        zero;
	wire [31:0] pcPlus4;
	wire [31:0] writeData;

	pcCounter #(.resetVector(resetVector)) pcCounter0 (
		.clk(clk), .rstN(rstN), .pcSel(pcSel), .branch(branch), .zero(zero),
		.halt(halt), .jalrTarget(aluResult), .immediate(imm),
		.pc(pc), .pcPlus4(pcPlus4)
	);

	instDecoder instDecoder0 (
		.inst(inst), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
		.imm(imm), .rd(rd), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.memSize(memSize), .memSigned(memSigned), .wbSel(wbSel), .pcSel(pcSel),
		.branch(branch), .invalid(invalid), .ebreak(ebreak), .halt(halt)
	);

	regFile regFile0 (
		.clk(clk), .rstN(rstN), .regWrite(regWrite), .rd(rd),
		.rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .writeData(writeData),
		.rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	alu alu0 (
		.aluOp(aluOp), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .pc(pc), .imm(imm),
		.result(aluResult), .zero(zero)
	);

	memWriteback memWriteback0 (
		.clk(clk), .rstN(rstN), .memWrite(memWrite), .memRead(memRead),
		.memSize(memSize), .memSigned(memSigned), .wbSel(wbSel),
		.aluResult(aluResult), .storeData(rs2Data), .pc(pc), .pcPlus4(pcPlus4),
		.imm(imm), .memRdata(memRdata), .memAddr(memAddr), .memWdata(memWdata),
		.memWmask(memWmask), .memWen(memWen), .memRen(memRen), .writeData(writeData)
	);

endmodule

`default_nettype wire

//--- cpuTopTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTopTb import rvIsaPkg::*;;

	localparam logic [31:0] resetVec = 32'h00002000;

	typedef struct {
		logic [31:0] inst;
		logic [31:0] pc;
		logic        inv;
		logic        eb;
		logic        wen;
		logic        ren;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [7:0]  mask;
	} tableRow_t;

	logic        clk;
	logic        rstN;
	logic [31:0] inst;
	wire  [31:0] memRdata;
	wire  [31:0] pc;
	wire         invalid;
	wire         ebreak;
	wire  [31:0] memAddr;
	wire  [31:0] memWdata;
	wire  [7:0]  memWmask;
	wire         memWen;
	wire         memRen;

	logic [7:0]  mem [256]; // data memory, low address byte only
	tableRow_t   rows[$];
	logic [31:0] progPc;
	int          curRow;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	int          maxCycles;

	cpuTop #(.resetVector(resetVec)) dut0 (
		.clk(clk), .rstN(rstN), .inst(inst), .memRdata(memRdata), .pc(pc),
		.invalid(invalid), .ebreak(ebreak), .memAddr(memAddr), .memWdata(memWdata),
		.memWmask(memWmask), .memWen(memWen), .memRen(memRen)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// combinational read, bytes from memAddr upward
	assign memRdata = {mem[memAddr[7:0] + 8'd3], mem[memAddr[7:0] + 8'd2],
		mem[memAddr[7:0] + 8'd1], mem[memAddr[7:0]]};

	always @(posedge clk) begin
		if (rstN && memWen) begin
			for (int b = 0; b < 4; b++) begin
				if (memWmask[b])
					mem[memAddr[7:0] + 8'(b)] <= memWdata[8*b +: 8];
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > maxCycles) begin
			$display("timeout: run did not complete within %0d cycles", maxCycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s (row %0d): got %h, expected %h", name, curRow, got, exp);
		end
	endtask

	function automatic rvInst_t rFormat(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		rvInst_t w;
		w = '0;
		w.rType.funct7 = f7;
		w.rType.rs2 = rs2;
		w.rType.rs1 = rs1;
		w.rType.funct3 = f3;
		w.rType.rd = rd;
		w.rType.opcode = opReg;
		return w;
	endfunction

	function automatic rvInst_t iFormat(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		rvInst_t w;
		w.iType.imm = imm;
		w.iType.rs1 = rs1;
		w.iType.funct3 = f3;
		w.iType.rd = rd;
		w.iType.opcode = op;
		return w;
	endfunction

	function automatic rvInst_t sFormat(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		rvInst_t w;
		w.sType.immHi = imm[11:5];
		w.sType.rs2 = rs2;
		w.sType.rs1 = rs1;
		w.sType.funct3 = f3;
		w.sType.immLo = imm[4:0];
		w.sType.opcode = opStore;
		return w;
	endfunction

	// beq only
	function automatic rvInst_t bFormat(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		rvInst_t w;
		w.bType.imm12 = imm[12];
		w.bType.imm10to5 = imm[10:5];
		w.bType.rs2 = rs2;
		w.bType.rs1 = rs1;
		w.bType.funct3 = f3Beq;
		w.bType.imm4to1 = imm[4:1];
		w.bType.imm11 = imm[11];
		w.bType.opcode = opBranch;
		return w;
	endfunction

	function automatic rvInst_t uFormat(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		rvInst_t w;
		w.uType.imm31to12 = imm;
		w.uType.rd = rd;
		w.uType.opcode = op;
		return w;
	endfunction

	function automatic rvInst_t jFormat(input logic [20:0] imm, input logic [4:0] rd);
		rvInst_t w;
		w.jType.imm20 = imm[20];
		w.jType.imm10to1 = imm[10:1];
		w.jType.imm11 = imm[11];
		w.jType.imm19to12 = imm[19:12];
		w.jType.rd = rd;
		w.jType.opcode = opJal;
		return w;
	endfunction

	// records the row at the current program pc
	task automatic pushRow(input rvInst_t w, input logic inv, input logic eb,
		input logic wen, input logic ren, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [7:0] mask);
		tableRow_t r;
		r.inst = w;
		r.pc = progPc;
		r.inv = inv;
		r.eb = eb;
		r.wen = wen;
		r.ren = ren;
		r.addr = addr;
		r.wdata = wdata;
		r.mask = mask;
		rows.push_back(r);
	endtask

	task automatic plainRow(input rvInst_t w);
		pushRow(w, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		progPc += 32'd4;
	endtask

	task automatic storeRow(input rvInst_t w, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [7:0] mask);
		pushRow(w, 1'b0, 1'b0, 1'b1, 1'b0, addr, wdata, mask);
		progPc += 32'd4;
	endtask

	// sw rs2, off(x0) showing a register value
	task automatic wordStore(input logic [4:0] rs2, input logic [11:0] off,
		input logic [31:0] value);
		storeRow(sFormat(off, rs2, 5'd0, f3Sw), {20'd0, off}, value, 8'h0f);
	endtask

	task automatic loadRow(input rvInst_t w, input logic [31:0] addr);
		pushRow(w, 1'b0, 1'b0, 1'b0, 1'b1, addr, '0, '0);
		progPc += 32'd4;
	endtask

	task automatic jumpRow(input rvInst_t w, input logic [31:0] target);
		pushRow(w, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		progPc = target;
	endtask

	task automatic haltRow(input rvInst_t w, input logic inv, input logic eb);
		pushRow(w, inv, eb, 1'b0, 1'b0, '0, '0, '0); // pc holds
	endtask

	task automatic buildTable();
		progPc = resetVec;
		plainRow(iFormat(12'd5, 5'd0, f3AddSub, 5'd1, opImm)); // x1 = 5
		plainRow(iFormat(12'hffd, 5'd0, f3AddSub, 5'd2, opImm)); // x2 = -3
		wordStore(5'd1, 12'h040, 32'h00000005);
		wordStore(5'd2, 12'h044, 32'hfffffffd);
		plainRow(rFormat(f7Alt, 5'd2, 5'd1, f3AddSub, 5'd3)); // sub
		plainRow(rFormat(f7Alt, 5'd1, 5'd2, f3SrlSra, 5'd4)); // sra
		plainRow(rFormat(f7Base, 5'd1, 5'd2, f3Slt, 5'd5));
		plainRow(rFormat(f7Base, 5'd2, 5'd1, f3Sltu, 5'd6));
		wordStore(5'd3, 12'h048, 32'h00000008);
		wordStore(5'd4, 12'h04c, 32'hffffffff);
		wordStore(5'd5, 12'h050, 32'h00000001);
		wordStore(5'd6, 12'h054, 32'h00000001);
		plainRow(uFormat(20'h12345, 5'd7, opLui));
		wordStore(5'd7, 12'h058, 32'h12345000);
		plainRow(uFormat(20'h00001, 5'd8, opAuipc)); // at 0x2038
		wordStore(5'd8, 12'h05c, 32'h00003038);
		plainRow(rFormat(f7Base, 5'd2, 5'd7, f3Xor, 5'd9));
		plainRow(rFormat(f7Base, 5'd1, 5'd1, f3Sll, 5'd10));
		plainRow(rFormat(f7Base, 5'd1, 5'd2, f3SrlSra, 5'd11));
		plainRow(rFormat(f7Base, 5'd1, 5'd7, f3Or, 5'd12));
		plainRow(rFormat(f7Base, 5'd2, 5'd7, f3And, 5'd13));
		plainRow(rFormat(f7Base, 5'd10, 5'd9, f3AddSub, 5'd14));
		plainRow(iFormat(12'hffe, 5'd2, f3Slt, 5'd15, opImm));
		plainRow(iFormat(12'hfff, 5'd1, f3Sltu, 5'd16, opImm));
		plainRow(iFormat(12'h0ff, 5'd1, f3Xor, 5'd17, opImm));
		plainRow(iFormat(12'h700, 5'd1, f3Or, 5'd18, opImm));
		plainRow(iFormat(12'h0f0, 5'd2, f3And, 5'd19, opImm));
		plainRow(iFormat(12'd7, 5'd1, f3AddSub, 5'd0, opImm)); // x0 must stay zero
		wordStore(5'd9, 12'h060, 32'hedcbaffd);
		wordStore(5'd10, 12'h064, 32'h000000a0);
		wordStore(5'd11, 12'h068, 32'h07ffffff);
		wordStore(5'd12, 12'h06c, 32'h12345005);
		wordStore(5'd13, 12'h070, 32'h12345000);
		wordStore(5'd14, 12'h074, 32'hedcbb09d);
		wordStore(5'd15, 12'h078, 32'h00000001);
		wordStore(5'd16, 12'h07c, 32'h00000001);
		wordStore(5'd17, 12'h080, 32'h000000fa);
		wordStore(5'd18, 12'h084, 32'h00000705);
		wordStore(5'd19, 12'h088, 32'h000000f0);
		wordStore(5'd0, 12'h08c, 32'h00000000);
		// narrow stores carry the full register, mask picks the bytes
		storeRow(sFormat(12'h090, 5'd9, 5'd0, f3Sb), 32'h90, 32'hedcbaffd, 8'h01);
		storeRow(sFormat(12'h094, 5'd9, 5'd0, f3Sh), 32'h94, 32'hedcbaffd, 8'h03);
		loadRow(iFormat(12'h090, 5'd0, f3Lb, 5'd20, opLoad), 32'h90);
		loadRow(iFormat(12'h090, 5'd0, f3Lbu, 5'd21, opLoad), 32'h90);
		loadRow(iFormat(12'h094, 5'd0, f3Lh, 5'd22, opLoad), 32'h94);
		loadRow(iFormat(12'h094, 5'd0, f3Lhu, 5'd23, opLoad), 32'h94);
		loadRow(iFormat(12'h074, 5'd0, f3Lw, 5'd24, opLoad), 32'h74);
		wordStore(5'd20, 12'h098, 32'hfffffffd);
		wordStore(5'd21, 12'h09c, 32'h000000fd);
		wordStore(5'd22, 12'h0a0, 32'hffffaffd);
		wordStore(5'd23, 12'h0a4, 32'h0000affd);
		wordStore(5'd24, 12'h0a8, 32'hedcbb09d);
		jumpRow(bFormat(13'h0010, 5'd1, 5'd1), 32'h000020e0); // taken
		jumpRow(bFormat(13'h0040, 5'd2, 5'd1), 32'h000020e4); // not taken
		jumpRow(jFormat(21'h000100, 5'd25), 32'h000021e4);
		wordStore(5'd25, 12'h0ac, 32'h000020e8);
		jumpRow(iFormat(12'h009, 5'd8, f3Jalr, 5'd26, opJalr), 32'h00003040);
		wordStore(5'd26, 12'h0b0, 32'h000021ec);
		jumpRow(bFormat(13'h1ff8, 5'd0, 5'd0), 32'h0000303c); // backward
		haltRow(rFormat(7'b0000001, 5'd1, 5'd1, f3AddSub, 5'd1), 1'b1, 1'b0); // mul
		haltRow(iFormat(12'h002, 5'd1, f3Sll, 5'd1, opImm), 1'b1, 1'b0);
		haltRow(sFormat(12'h040, 5'd1, 5'd0, 3'b011), 1'b1, 1'b0);
		haltRow(instEbreak, 1'b0, 1'b1);
		wordStore(5'd1, 12'h0b4, 32'h00000005); // x1 untouched by halted rows
	endtask

	initial begin
		rstN = 1'b0;
		inst = iFormat(12'd0, 5'd0, f3AddSub, 5'd0, opImm); // nop during reset
		for (int k = 0; k < 256; k++) begin
			mem[k] = 8'(k) ^ 8'h5a;
		end
		buildTable();
		maxCycles = rows.size() + 2 + 20;
		curRow = -1;

		@(posedge clk);
		#1;
		checkValue("pc", pc, resetVec);
		checkValue("memWen", {31'd0, memWen}, 32'd0);
		checkValue("memRen", {31'd0, memRen}, 32'd0);
		@(posedge clk);
		#1;
		rstN = 1'b1;

		for (int i = 0; i < rows.size(); i++) begin
			curRow = i;
			inst = rows[i].inst;
			#4;
			checkValue("pc", pc, rows[i].pc);
			checkValue("invalid", {31'd0, invalid}, {31'd0, rows[i].inv});
			checkValue("ebreak", {31'd0, ebreak}, {31'd0, rows[i].eb});
			checkValue("memWen", {31'd0, memWen}, {31'd0, rows[i].wen});
			checkValue("memRen", {31'd0, memRen}, {31'd0, rows[i].ren});
			if (rows[i].wen || rows[i].ren)
				checkValue("memAddr", memAddr, rows[i].addr);
			if (rows[i].wen) begin
				checkValue("memWdata", memWdata, rows[i].wdata);
				checkValue("memWmask", {24'd0, memWmask}, {24'd0, rows[i].mask});
			end
			@(posedge clk);
			#1;
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rvIsaPkg.sv
cpuCtrlPkg.sv
pcCounter.sv
regFile.sv
instDecoder.sv
alu.sv
memWriteback.sv
cpuTop.sv
cpuTopTb.sv
